//--- source/ch_est_pkg.sv
package ch_est_pkg;

    // ========================================
    // shift case and control bundles
    // ========================================

    // pilot shift case, decoded from v_shift
    typedef enum logic [1:0] {
        shift_0 = 2'd0,
        shift_1 = 2'd1,
        shift_2 = 2'd2
    } shift_mode_t;

    // estimates 2 and 3 ready, from add burst slots 1 and 2
    typedef struct packed {
        logic e2_ready;
        logic e3_ready;
    } est_ready_t;

    // demapper read side
    typedef struct packed {
        logic [3:0] col;
        logic [1:0] nrs_index_addr;
        logic       demap_read;
    } demap_ctrl_t;

    // product and average memories
    typedef struct packed {
        logic [1:0] addr_mem;
        logic       mult_mem_en;
        logic       avg_mem_en;
    } mem_ctrl_t;

    // estimate registers and adder mux selects
    typedef struct packed {
        logic       en_reg_e;
        logic       en_reg_2e;
        logic       en_reg_5e;
        logic [2:0] s1a;
        logic [2:0] s1b;
        logic [2:0] s2a;
        logic [2:0] s2b;
        logic       s_est;
    } interp_ctrl_t;

    // interp events that drive the output select sequencer
    typedef struct packed {
        logic load_sel;
        logic valid_set;
        logic valid_clear;
    } interp_status_t;

    // equalizer out mux selects
    typedef struct packed {
        logic [1:0] s_h1;
        logic [1:0] s_h2;
        logic       valid_eqlz;
    } eqlz_out_t;

    // ========================================
    // constants
    // ========================================

    // adder mux select while the adder is idle
    localparam logic [2:0] sel_idle = 3'd7;

    // six 2-bit entries per select sequence
    localparam int out_sel_len = 12;

    // demapper pilot columns, entry 0 first
    localparam logic [3:0][3:0] pilot_cols = {4'd13, 4'd12, 4'd6, 4'd5};

    // out select tables, lowest entry goes out first
    localparam logic [out_sel_len-1:0] shift0_h1_seq = 12'b01_11_10_11_01_00;
    localparam logic [out_sel_len-1:0] shift0_h2_seq = 12'b10_11_00_00_01_00;
    localparam logic [out_sel_len-1:0] shift1_h1_seq = 12'b10_11_01_00_01_01;
    localparam logic [out_sel_len-1:0] shift1_h2_seq = 12'b00_10_11_10_10_01;
    localparam logic [out_sel_len-1:0] shift2_h1_seq = 12'b01_10_11_11_00_11;
    localparam logic [out_sel_len-1:0] shift2_h2_seq = 12'b11_10_00_01_00_00;

endpackage

//--- source/demap_sequencer.sv
`timescale 1ns/1ps

module demap_sequencer
    import ch_est_pkg::*;
#(
    parameter int nrs_addr_width = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      demap_ready,
    input  logic                      nrs_gen_ready,
    output demap_ctrl_t               demap,
    output logic [nrs_addr_width-1:0] rd_addr_nrs,
    output mem_ctrl_t                 mem,
    output est_ready_t                ready
);

    // multiply phase, store slot then add slot
    typedef enum logic [1:0] {
        st_idle  = 2'b00,
        st_store = 2'b01,
        st_add   = 2'b11
    } mult_state_t;

    mult_state_t cs;
    mult_state_t ns;
    logic [1:0]  cnt;
    logic        cnt_done;
    logic        busy;
    logic        first_slot;
    logic [1:0]  col_addr;
    logic [1:0]  nrs_index_addr;
    logic        mult_en_q;
    logic        avg_en_q;

    assign busy     = (cs != st_idle);
    assign cnt_done = (cnt == 2'd3);

    // ========================================
    // burst state machine
    // ========================================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cs <= st_idle;
        end else begin
            cs <= ns;
        end
    end

    // readies only looked at in idle, no back-pressure mid burst
    always_comb begin
        ns = cs;
        case (cs)
            st_idle: begin
                if (demap_ready && nrs_gen_ready) begin
                    ns = first_slot ? st_store : st_add;
                end
            end
            st_store, st_add: begin
                if (cnt_done) begin
                    ns = st_idle;
                end
            end
            default: ns = st_idle;
        endcase
    end

    // burst counter wraps on its own after four reads
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt        <= 2'd0;
            first_slot <= 1'b1;
            col_addr   <= 2'd0;
        end else if (busy) begin
            cnt <= cnt + 2'd1;
            // slot flips at the end of every burst
            if (cnt_done) begin
                first_slot <= !first_slot;
            end
            // each column is read twice
            if (cnt[0]) begin
                col_addr <= col_addr + 2'd1;
            end
        end
    end

    // ========================================
    // pilot addresses and memory enables
    // ========================================

    // two reference symbols per pilot read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            nrs_index_addr <= 2'd0;
            rd_addr_nrs    <= '0;
        end else if (busy) begin
            nrs_index_addr <= nrs_index_addr + 2'd1;
            rd_addr_nrs    <= rd_addr_nrs + nrs_addr_width'(2);
        end
    end

    // product lands one cycle after the read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mult_en_q <= 1'b0;
            avg_en_q  <= 1'b0;
        end else begin
            mult_en_q <= (cs == st_store);
            avg_en_q  <= (cs == st_add);
        end
    end

    always_comb begin
        demap.col            = pilot_cols[col_addr];
        demap.nrs_index_addr = nrs_index_addr;
        demap.demap_read     = busy;
        mem.addr_mem         = cnt;
        mem.mult_mem_en      = mult_en_q;
        mem.avg_mem_en       = avg_en_q;
        // estimate 2 and 3 averages become available mid add burst
        ready.e2_ready       = (cs == st_add) && (cnt == 2'd1);
        ready.e3_ready       = (cs == st_add) && (cnt == 2'd2);
    end

    // store and add never write in the same cycle
    a_mem_en_excl: assert property (@(posedge clk) disable iff (!rst)
        !(mem.mult_mem_en && mem.avg_mem_en));

    // a burst is four reads, then at least one idle cycle
    a_burst_len: assert property (@(posedge clk) disable iff (!rst)
        demap.demap_read [*4] |=> !demap.demap_read);

endmodule

//--- source/interp_sequencer.sv
`timescale 1ns/1ps

module interp_sequencer
    import ch_est_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic [2:0]     v_shift,
    input  est_ready_t     ready,
    output shift_mode_t    shift,
    output interp_ctrl_t   ctrl,
    output interp_status_t status
);

    // adder 1 states named after the sum they form
    typedef enum logic [3:0] {
        a1_idle    = 4'b0000,
        a1_e2      = 4'b0010,
        a1_2e2     = 4'b0011,
        a1_e2_2e3  = 4'b0001,
        a1_e2_2e4  = 4'b0100,
        a1_2e2_5e4 = 4'b0101,
        a1_2e3_e1  = 4'b1000,
        a1_2e3     = 4'b1100,
        a1_5e1_2e3 = 4'b1110
    } a1_state_t;

    // adder 2 states
    typedef enum logic [3:0] {
        a2_idle   = 4'b0000,
        a2_2e1_e3 = 4'b0001,
        a2_e1_2e3 = 4'b0011,
        a2_2e2_e3 = 4'b0010,
        a2_2e2_e4 = 4'b0100,
        a2_5e4    = 4'b0101,
        a2_4e4_e2 = 4'b0111,
        a2_e3     = 4'b1000,
        a2_4e1_e3 = 4'b1010,
        a2_5e1    = 4'b1011
    } a2_state_t;

    a1_state_t  cs_a1;
    a1_state_t  ns_a1;
    a2_state_t  cs_a2;
    a2_state_t  ns_a2;
    logic       go_1;
    logic       go_2;
    logic [5:0] sel_a1;
    logic [5:0] sel_a2;

    // ========================================
    // shift decode
    // ========================================

    always_comb begin
        case (v_shift)
            3'd0, 3'd3: shift = shift_0;
            3'd1, 3'd4: shift = shift_1;
            default:    shift = shift_2;
        endcase
    end

    // ========================================
    // adder state machines
    // ========================================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cs_a1 <= a1_idle;
            cs_a2 <= a2_idle;
        end else begin
            cs_a1 <= ns_a1;
            cs_a2 <= ns_a2;
        end
    end

    // unlisted states fall back to idle
    always_comb begin
        ns_a1 = a1_idle;
        ns_a2 = a2_idle;
        case (shift)
            shift_0: begin
                case (cs_a1)
                    a1_idle:    ns_a1 = ready.e2_ready ? a1_e2 : a1_idle;
                    a1_e2:      ns_a1 = a1_2e2;
                    a1_2e2:     ns_a1 = go_1 ? a1_e2_2e3 : a1_2e2;
                    a1_e2_2e3:  ns_a1 = go_1 ? a1_e2_2e4 : a1_e2_2e3;
                    a1_e2_2e4:  ns_a1 = a1_2e2_5e4;
                    default:    ns_a1 = a1_idle;
                endcase
                case (cs_a2)
                    a2_idle:    ns_a2 = ready.e3_ready ? a2_2e1_e3 : a2_idle;
                    a2_2e1_e3:  ns_a2 = a2_e1_2e3;
                    a2_e1_2e3:  ns_a2 = a2_2e2_e3;
                    a2_2e2_e3:  ns_a2 = a2_2e2_e4;
                    a2_2e2_e4:  ns_a2 = a2_5e4;
                    a2_5e4:     ns_a2 = a2_4e4_e2;
                    default:    ns_a2 = a2_idle;
                endcase
            end
            shift_1: begin
                // adder 1 trails adder 2 here
                case (cs_a1)
                    a1_idle:    ns_a1 = (cs_a2 == a2_4e1_e3) ? a1_2e3_e1 : a1_idle;
                    a1_2e3_e1:  ns_a1 = a1_e2_2e3;
                    a1_e2_2e3:  ns_a1 = a1_e2;
                    a1_e2:      ns_a1 = a1_e2_2e4;
                    default:    ns_a1 = a1_idle;
                endcase
                case (cs_a2)
                    a2_idle:    ns_a2 = ready.e3_ready ? a2_e3 : a2_idle;
                    a2_e3:      ns_a2 = a2_4e1_e3;
                    a2_4e1_e3:  ns_a2 = a2_2e1_e3;
                    a2_2e1_e3:  ns_a2 = go_2 ? a2_2e2_e3 : a2_2e1_e3;
                    a2_2e2_e3:  ns_a2 = a2_2e2_e4;
                    a2_2e2_e4:  ns_a2 = a2_4e4_e2;
                    default:    ns_a2 = a2_idle;
                endcase
            end
            default: begin
                case (cs_a1)
                    a1_idle:    ns_a1 = ready.e3_ready ? a1_2e3 : a1_idle;
                    a1_2e3:     ns_a1 = a1_5e1_2e3;
                    a1_5e1_2e3: ns_a1 = go_1 ? a1_2e3_e1 : a1_5e1_2e3;
                    a1_2e3_e1:  ns_a1 = a1_e2_2e3;
                    a1_e2_2e3:  ns_a1 = go_1 ? a1_e2_2e4 : a1_e2_2e3;
                    default:    ns_a1 = a1_idle;
                endcase
                case (cs_a2)
                    a2_idle:    ns_a2 = ready.e2_ready ? a2_5e1 : a2_idle;
                    a2_5e1:     ns_a2 = a2_e3;
                    a2_e3:      ns_a2 = a2_4e1_e3;
                    a2_4e1_e3:  ns_a2 = a2_2e1_e3;
                    a2_2e1_e3:  ns_a2 = go_2 ? a2_2e2_e3 : a2_2e1_e3;
                    a2_2e2_e3:  ns_a2 = a2_2e2_e4;
                    default:    ns_a2 = a2_idle;
                endcase
            end
        endcase
    end

    // go pulses hold a waiting state for one extra cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            go_1 <= 1'b0;
            go_2 <= 1'b0;
        end else begin
            go_1 <= !go_1 && (cs_a1 inside {a1_2e2, a1_e2_2e3, a1_5e1_2e3});
            go_2 <= !go_2 && (cs_a2 == a2_2e1_e3);
        end
    end

    // ========================================
    // mux selects and register enables
    // ========================================

    // {s1a, s1b}
    always_comb begin
        case (cs_a1)
            a1_e2:      sel_a1 = {3'd0, 3'd0};
            a1_2e2:     sel_a1 = {3'd1, 3'd0};
            a1_e2_2e3:  sel_a1 = {3'd3, 3'd1};
            a1_e2_2e4:  sel_a1 = {3'd3, 3'd3};
            a1_2e2_5e4: sel_a1 = {3'd2, 3'd2};
            a1_2e3_e1:  sel_a1 = {3'd6, 3'd6};
            a1_2e3:     sel_a1 = {3'd4, 3'd0};
            a1_5e1_2e3: sel_a1 = {3'd5, 3'd4};
            default:    sel_a1 = {sel_idle, sel_idle};
        endcase
    end

    // {s2a, s2b}
    always_comb begin
        case (cs_a2)
            a2_2e1_e3: sel_a2 = {3'd0, 3'd0};
            a2_e1_2e3: sel_a2 = {3'd1, 3'd1};
            a2_2e2_e3: sel_a2 = {3'd3, 3'd0};
            a2_2e2_e4: sel_a2 = {3'd3, 3'd3};
            a2_5e4:    sel_a2 = {3'd2, 3'd3};
            a2_4e4_e2: sel_a2 = {3'd2, 3'd2};
            a2_e3:     sel_a2 = {3'd6, 3'd6};
            a2_4e1_e3: sel_a2 = {3'd4, 3'd4};
            a2_5e1:    sel_a2 = {3'd1, 3'd4};
            default:   sel_a2 = {sel_idle, sel_idle};
        endcase
    end

    // enable rides on the state whose sum is ready at its end
    always_comb begin
        ctrl.en_reg_e  = (shift == shift_0 && cs_a1 == a1_2e2)
                      || (shift == shift_1 && cs_a1 == a1_e2_2e4);
        // shift_1 stores -e3 in the 2e register
        ctrl.en_reg_2e = (shift == shift_0 && cs_a1 == a1_e2_2e3)
                      || (shift == shift_1 && cs_a2 == a2_4e1_e3)
                      || (shift == shift_2 && cs_a1 == a1_5e1_2e3);
        // 5e written when adder 1 ends on 2e2+5e4 beside adder 2
        ctrl.en_reg_5e = (cs_a1 == a1_2e2_5e4) && (cs_a2 == a2_4e4_e2);
        {ctrl.s1a, ctrl.s1b} = sel_a1;
        {ctrl.s2a, ctrl.s2b} = sel_a2;
        // out mux pairs swap only for shift_1
        ctrl.s_est = shift[0];
    end

    // load two cycles ahead of valid and clear as the last adder goes idle
    always_comb begin
        status.load_sel    = (shift == shift_0 && cs_a1 == a1_e2) || (cs_a2 == a2_e3);
        status.valid_set   = (shift == shift_0 && cs_a2 == a2_2e1_e3)
                          || (cs_a2 == a2_4e1_e3);
        status.valid_clear = (shift == shift_2) ? (ns_a1 == a1_idle) : (ns_a2 == a2_idle);
    end

    // shift_1 has no 5e estimate
    a_no_5e_shift1: assert property (@(posedge clk) disable iff (!rst)
        $rose(ctrl.en_reg_5e) |-> shift != shift_1);

endmodule

//--- source/eqlz_select_sequencer.sv
`timescale 1ns/1ps

module eqlz_select_sequencer
    import ch_est_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  shift_mode_t    shift,
    input  interp_status_t status,
    output eqlz_out_t      eqlz
);

    logic [out_sel_len-1:0] h1_seq;
    logic [out_sel_len-1:0] h2_seq;
    logic                   sh;
    logic                   valid_q;

    // ========================================
    // select sequence registers
    // ========================================

    // load, one extra shift, then shift while valid
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            h1_seq <= '0;
            h2_seq <= '0;
            sh     <= 1'b0;
        end else if (status.load_sel) begin
            sh <= 1'b1;
            case (shift)
                shift_0: begin
                    h1_seq <= shift0_h1_seq;
                    h2_seq <= shift0_h2_seq;
                end
                shift_1: begin
                    h1_seq <= shift1_h1_seq;
                    h2_seq <= shift1_h2_seq;
                end
                default: begin
                    h1_seq <= shift2_h1_seq;
                    h2_seq <= shift2_h2_seq;
                end
            endcase
        end else if (sh || valid_q) begin
            h1_seq <= h1_seq >> 2;
            h2_seq <= h2_seq >> 2;
            sh     <= 1'b0;
        end
    end

    // clear wins, it holds while the adders sit idle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else if (status.valid_clear) begin
            valid_q <= 1'b0;
        end else if (status.valid_set) begin
            valid_q <= 1'b1;
        end
    end

    always_comb begin
        eqlz.s_h1       = h1_seq[1:0];
        eqlz.s_h2       = h2_seq[1:0];
        eqlz.valid_eqlz = valid_q;
    end

    // a new load would cut off the running sequence
    a_no_load_in_valid: assert property (@(posedge clk) disable iff (!rst)
        status.load_sel |-> !eqlz.valid_eqlz);

endmodule

//--- source/ch_est_ctrl.sv
`timescale 1ns/1ps

module ch_est_ctrl
    import ch_est_pkg::*;
#(
    parameter int nrs_addr_width = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      demap_ready,
    input  logic                      nrs_gen_ready,
    input  logic [2:0]                v_shift,
    output demap_ctrl_t               demap,
    output logic [nrs_addr_width-1:0] rd_addr_nrs,
    output mem_ctrl_t                 mem,
    output interp_ctrl_t              interp,
    output eqlz_out_t                 eqlz
);

    est_ready_t     est_ready;
    shift_mode_t    shift;
    interp_status_t interp_status;

    // ========================================
    // multiply, interpolate, select
    // ========================================

    demap_sequencer #(
        .nrs_addr_width(nrs_addr_width)
    ) demap_seq0 (
        .clk          (clk),
        .rst          (rst),
        .demap_ready  (demap_ready),
        .nrs_gen_ready(nrs_gen_ready),
        .demap        (demap),
        .rd_addr_nrs  (rd_addr_nrs),
        .mem          (mem),
        .ready        (est_ready)
    );

    interp_sequencer interp_seq0 (
        .clk    (clk),
        .rst    (rst),
        .v_shift(v_shift),
        .ready  (est_ready),
        .shift  (shift),
        .ctrl   (interp),
        .status (interp_status)
    );

    eqlz_select_sequencer eqlz_seq0 (
        .clk   (clk),
        .rst   (rst),
        .shift (shift),
        .status(interp_status),
        .eqlz  (eqlz)
    );

endmodule

//--- sim/ch_est_ctrl_tb.sv
`timescale 1ns/1ps

module ch_est_ctrl_tb
    import ch_est_pkg::*;
;

    localparam int nrs_addr_width = 4;
    localparam int n_pairs        = 30;
    localparam int pair_cycles    = 60;
    localparam int watchdog_ns    = n_pairs * pair_cycles * 4 + 400;

    // own copies of the pilot columns and select tables, index 0 first
    localparam logic [3:0][3:0]  col_tbl = {4'd13, 4'd12, 4'd6, 4'd5};
    localparam logic [2:0][11:0] h1_tbl  = {
        12'b01_10_11_11_00_11, 12'b10_11_01_00_01_01, 12'b01_11_10_11_01_00
    };
    localparam logic [2:0][11:0] h2_tbl  = {
        12'b11_10_00_01_00_00, 12'b00_10_11_10_10_01, 12'b10_11_00_00_01_00
    };

    logic                      clk;
    logic                      rst;
    logic                      demap_ready;
    logic                      nrs_gen_ready;
    logic [2:0]                v_shift;
    demap_ctrl_t               demap;
    logic [nrs_addr_width-1:0] rd_addr_nrs;
    mem_ctrl_t                 mem;
    interp_ctrl_t              interp;
    eqlz_out_t                 eqlz;

    integer seed;

    // demap model state
    logic                      m_busy;
    logic                      m_store;
    logic                      m_next_store;
    logic [1:0]                m_idx;
    logic [1:0]                m_col;
    logic [1:0]                m_nrs;
    logic [nrs_addr_width-1:0] m_rd;
    logic                      m_mult;
    logic                      m_avg;

    // equalizer select tracking
    logic                      eq_armed;
    logic                      eq_high;
    shift_mode_t               eq_sh;
    int                        eq_k;
    int                        eq_wait;
    int                        eq_done;

    ch_est_ctrl #(
        .nrs_addr_width(nrs_addr_width)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .demap_ready  (demap_ready),
        .nrs_gen_ready(nrs_gen_ready),
        .v_shift      (v_shift),
        .demap        (demap),
        .rd_addr_nrs  (rd_addr_nrs),
        .mem          (mem),
        .interp       (interp),
        .eqlz         (eqlz)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // failure reporting and compare tasks
    // ========================================

    task automatic stop_run(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(string msg);
        stop_run($sformatf("FAILED at %0t ns: %s", $time, msg));
    endtask

    task automatic check_demap(demap_ctrl_t got, demap_ctrl_t exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s col %0d idx %0d read %b, expected %0d %0d %b",
                what, got.col, got.nrs_index_addr, got.demap_read,
                exp.col, exp.nrs_index_addr, exp.demap_read));
        end
    endtask

    task automatic check_addr(logic [nrs_addr_width-1:0] got,
                              logic [nrs_addr_width-1:0] exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_mem(mem_ctrl_t got, mem_ctrl_t exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s addr %0d mult %b avg %b, expected %0d %b %b",
                what, got.addr_mem, got.mult_mem_en, got.avg_mem_en,
                exp.addr_mem, exp.mult_mem_en, exp.avg_mem_en));
        end
    endtask

    task automatic check_interp(interp_ctrl_t got, interp_ctrl_t exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_eqlz(eqlz_out_t got, eqlz_out_t exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s h1 %0d h2 %0d valid %b, expected %0d %0d %b",
                what, got.s_h1, got.s_h2, got.valid_eqlz,
                exp.s_h1, exp.s_h2, exp.valid_eqlz));
        end
    endtask

    // ========================================
    // reference model
    // ========================================

    function automatic shift_mode_t decode_shift(logic [2:0] v);
        shift_mode_t s;
        case (v)
            3'd0, 3'd3: s = shift_0;
            3'd1, 3'd4: s = shift_1;
            default:    s = shift_2;
        endcase
        return s;
    endfunction

    // both adders parked, selects at 7
    function automatic interp_ctrl_t idle_interp(shift_mode_t s);
        interp_ctrl_t c;
        c.en_reg_e  = 1'b0;
        c.en_reg_2e = 1'b0;
        c.en_reg_5e = 1'b0;
        c.s1a       = 3'd7;
        c.s1b       = 3'd7;
        c.s2a       = 3'd7;
        c.s2b       = 3'd7;
        c.s_est     = (s == shift_1);
        return c;
    endfunction

    task automatic check_interp_rules();
        shift_mode_t s;
        s = decode_shift(v_shift);
        if (interp.s_est !== (s == shift_1)) begin
            report_mismatch($sformatf("s_est %b for v_shift %0d", interp.s_est, v_shift));
        end
        if (s == shift_1 && interp.en_reg_5e !== 1'b0) begin
            report_mismatch("en_reg_5e high in shift_1");
        end
        if (s == shift_2 && interp.en_reg_e !== 1'b0) begin
            report_mismatch("en_reg_e high in shift_2");
        end
    endtask

    // entry 0 goes out in the post-load shift, so entry 1 leads
    task automatic track_eqlz();
        eqlz_out_t exp;
        if (eqlz.valid_eqlz) begin
            if (!eq_armed) begin
                stop_run("valid_eqlz went high without an add burst");
            end
            eq_k = eq_k + 1;
            if (eq_k >= 6) begin
                stop_run("valid_eqlz stayed high past the last select entry");
            end
            exp.s_h1       = h1_tbl[eq_sh][2*eq_k +: 2];
            exp.s_h2       = h2_tbl[eq_sh][2*eq_k +: 2];
            exp.valid_eqlz = 1'b1;
            check_eqlz(eqlz, exp, "equalizer select");
            eq_high = 1'b1;
        end else if (eq_high) begin
            eq_high  = 1'b0;
            eq_armed = 1'b0;
            eq_done  = eq_done + 1;
        end else if (eq_armed) begin
            eq_wait = eq_wait + 1;
            if (eq_wait > 40) begin
                stop_run("valid_eqlz did not rise within 40 cycles of the add burst");
            end
        end
    endtask

    // one clock: model steps on the rising edge, outputs checked on the falling one
    task automatic tick();
        demap_ctrl_t dexp;
        mem_ctrl_t   mexp;
        logic        mult_n;
        logic        avg_n;
        @(posedge clk);
        mult_n = m_busy && m_store;
        avg_n  = m_busy && !m_store;
        if (m_busy) begin
            m_nrs = m_nrs + 2'd1;
            m_rd  = m_rd + nrs_addr_width'(2);
            // column held for two reads
            if (m_idx[0]) begin
                m_col = m_col + 2'd1;
            end
            if (m_idx == 2'd3) begin
                m_busy       = 1'b0;
                m_next_store = !m_next_store;
            end
            m_idx = m_idx + 2'd1;
        end else if (demap_ready && nrs_gen_ready) begin
            m_busy  = 1'b1;
            m_store = m_next_store;
            if (!m_next_store) begin
                eq_armed = 1'b1;
                eq_wait  = 0;
                eq_k     = 0;
                eq_sh    = decode_shift(v_shift);
            end
        end
        m_mult = mult_n;
        m_avg  = avg_n;
        @(negedge clk);
        dexp.col            = col_tbl[m_col];
        dexp.nrs_index_addr = m_nrs;
        dexp.demap_read     = m_busy;
        check_demap(demap, dexp, "demap");
        check_addr(rd_addr_nrs, m_rd, "rd_addr_nrs");
        mexp.addr_mem    = m_idx;
        mexp.mult_mem_en = m_mult;
        mexp.avg_mem_en  = m_avg;
        check_mem(mem, mexp, "memory");
        check_interp_rules();
        track_eqlz();
    endtask

    // ========================================
    // stimulus
    // ========================================

    task automatic request_burst();
        int gap;
        gap = {$random(seed)} % 6;
        repeat (gap) begin
            tick();
            check_interp(interp, idle_interp(decode_shift(v_shift)), "interp before burst");
        end
        demap_ready   = 1'b1;
        nrs_gen_ready = 1'b1;
        tick();
        demap_ready   = 1'b0;
        nrs_gen_ready = 1'b0;
        // three more reads, then one idle cycle
        repeat (4) tick();
    endtask

    task automatic run_pair();
        v_shift = 3'($random(seed));
        request_burst();
        request_burst();
        repeat (40) tick();
        if (eq_armed) begin
            stop_run("valid_eqlz did not fall within 40 cycles after the add burst");
        end
        check_interp(interp, idle_interp(decode_shift(v_shift)), "interp after sequence");
    endtask

    initial begin
        seed          = 26332;
        rst           = 1'b0;
        demap_ready   = 1'b0;
        nrs_gen_ready = 1'b0;
        v_shift       = 3'd0;
        m_busy        = 1'b0;
        m_store       = 1'b0;
        m_next_store  = 1'b1;
        m_idx         = 2'd0;
        m_col         = 2'd0;
        m_nrs         = 2'd0;
        m_rd          = '0;
        m_mult        = 1'b0;
        m_avg         = 1'b0;
        eq_armed      = 1'b0;
        eq_high       = 1'b0;
        eq_sh         = shift_0;
        eq_k          = 0;
        eq_wait       = 0;
        eq_done       = 0;
        repeat (4) @(negedge clk);
        // reset values, still inside reset
        check_demap(demap, '{col: col_tbl[0], nrs_index_addr: 2'd0, demap_read: 1'b0},
            "demap in reset");
        check_addr(rd_addr_nrs, '0, "rd_addr_nrs in reset");
        check_mem(mem, '0, "memory in reset");
        check_interp(interp, idle_interp(shift_0), "interp in reset");
        check_eqlz(eqlz, '0, "equalizer in reset");
        rst = 1'b1;
        repeat (n_pairs) run_pair();
        if (eq_done != n_pairs) begin
            stop_run($sformatf("only %0d of %0d select sequences completed",
                eq_done, n_pairs));
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(watchdog_ns);
        stop_run($sformatf("timeout, run still going after %0d ns", watchdog_ns));
    end

endmodule

//--- verilog.f
source/ch_est_pkg.sv
source/demap_sequencer.sv
source/interp_sequencer.sv
source/eqlz_select_sequencer.sv
source/ch_est_ctrl.sv
sim/ch_est_ctrl_tb.sv

//--- Makefile
TOP = ch_est_ctrl_tb

.PHONY: all lint clean

all:
	verilator --binary --top-module $(TOP) -f verilog.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f
	verilator --lint-only --timing --top-module ch_est_ctrl -f verilog.f

clean:
	rm -rf obj_dir
